// ==== source/interp_pkg.sv ====
`default_nettype none

package interp_pkg;

	// Input sample width, two's complement.
	localparam int sample_w = 9;

	// Output sample width.
	// Also the accumulator width.
	localparam int out_w = 20;

	// Coefficient width, two's complement.
	localparam int coef_w = 10;

	// Filter length and tap index width.
	localparam int num_taps = 16;
	localparam int tap_idx_w = 4;

	// Index of the last tap.
	localparam logic [tap_idx_w-1:0] tap_last = tap_idx_w'(num_taps - 1);

	// Clock cycles per slot.
	localparam int slot_period = 42;
	localparam int slot_cnt_w = 6;

	// Terminal count of the slot counter.
	localparam logic [slot_cnt_w-1:0] slot_last = slot_cnt_w'(slot_period - 1);

	// One coefficient.
	typedef logic signed [coef_w-1:0] coef_t;

	// Symmetric low-pass set, index 0 pairs with the newest sample.
	// Magnitudes sum to 958.
	// So 16 full-scale products stay well inside out_w bits.
	localparam coef_t coef_table [0:num_taps-1] = '{
		-10'sd3, -10'sd8, -10'sd6, 10'sd12,
		10'sd48, 10'sd96, 10'sd140, 10'sd166,
		10'sd166, 10'sd140, 10'sd96, 10'sd48,
		10'sd12, -10'sd6, -10'sd8, -10'sd3
	};

	// Stereo input pair.
	typedef struct packed {
		logic signed [sample_w-1:0] left;
		logic signed [sample_w-1:0] right;
	} stereo_t;

	// Stereo output pair.
	typedef struct packed {
		logic signed [out_w-1:0] left;
		logic signed [out_w-1:0] right;
	} stereo_out_t;

	// Slot order within one frame period.
	// Zero slots stuff zeros between real samples.
	typedef enum logic [1:0] {
		slot_fm,
		slot_zero_a,
		slot_other,
		slot_zero_b
	} slot_e;

	// Filter control states.
	typedef enum logic [1:0] {
		mac_idle,
		mac_shift,
		mac_run,
		mac_emit
	} mac_state_e;

endpackage

`default_nettype wire

// ==== source/slot_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

// Free-running slot timer.
// Divides the clock into slots of slot_period cycles.
module slot_timer (
	input  logic clk,
	input  logic rst,
	output logic slot_tick
);

	// Position within the current slot.
	logic [interp_pkg::slot_cnt_w-1:0] cnt;

	// Counts 0 up to the terminal count, then wraps.
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
		end else if (cnt == interp_pkg::slot_last) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// One tick per slot, on the terminal count.
	// Counter is zero in reset, so the tick is low there too.
	assign slot_tick = (cnt == interp_pkg::slot_last);

	// Tick must stay a single-cycle strobe.
	// The sequencer advances one slot per high cycle.
	a_tick_single : assert property (
		@(posedge clk) disable iff (rst)
		slot_tick |=> !slot_tick
	);

endmodule

`default_nettype wire

// ==== source/slot_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

// Four-slot frame source for the filter.
// FM pair, zeros, other pair, zeros.
module slot_sequencer (
	input  logic                clk,
	input  logic                rst,
	input  logic                slot_tick,
	input  interp_pkg::stereo_t fm_in,
	input  interp_pkg::stereo_t other_in,
	output interp_pkg::stereo_t frame,
	output logic                frame_valid
);

	// Current slot.
	interp_pkg::slot_e slot;
	interp_pkg::slot_e slot_next;

	// Pair selected for the current slot.
	interp_pkg::stereo_t pick;

	// Source select.
	// Both zero slots feed silence.
	always_comb begin
		case (slot)
			interp_pkg::slot_fm:    pick = fm_in;
			interp_pkg::slot_other: pick = other_in;
			default:                pick = '0;
		endcase
	end

	// Slot order wraps after slot_zero_b.
	always_comb begin
		case (slot)
			interp_pkg::slot_fm:     slot_next = interp_pkg::slot_zero_a;
			interp_pkg::slot_zero_a: slot_next = interp_pkg::slot_other;
			interp_pkg::slot_other:  slot_next = interp_pkg::slot_zero_b;
			default:                 slot_next = interp_pkg::slot_fm;
		endcase
	end

	// Sources are sampled only on the tick edge.
	// Frame then holds until the next tick.
	always_ff @(posedge clk) begin
		if (rst) begin
			slot        <= interp_pkg::slot_fm;
			frame       <= '0;
			frame_valid <= 1'b0;
		end else begin
			// Strobe follows the tick by one cycle.
			frame_valid <= slot_tick;
			if (slot_tick) begin
				frame <= pick;
				slot  <= slot_next;
			end
		end
	end

	// A zero slot must hand the filter a true zero pair.
	// Otherwise the up-sampling images are not suppressed.
	a_zero_slot : assert property (
		@(posedge clk) disable iff (rst)
		slot_tick && (slot == interp_pkg::slot_zero_a || slot == interp_pkg::slot_zero_b)
		|=> frame == '0
	);

endmodule

`default_nettype wire

// ==== source/fir_mac.sv ====
`timescale 1ns/100ps
`default_nettype none

// Stereo 16-tap FIR.
// One tap per clock through a shared multiply-accumulate.
module fir_mac (
	input  logic                    clk,
	input  logic                    rst,
	input  interp_pkg::stereo_t     frame,
	input  logic                    frame_valid,
	output interp_pkg::stereo_out_t audio_out,
	output logic                    sample_out
);

	// Sample history, newest at index 0.
	interp_pkg::stereo_t hist [0:interp_pkg::num_taps-1];

	// Control.
	interp_pkg::mac_state_e state;
	logic [interp_pkg::tap_idx_w-1:0] tap_idx;

	// Running sums for both channels.
	interp_pkg::stereo_out_t acc;

	// Operands for the current tap.
	logic signed [interp_pkg::coef_w-1:0]   coef_cur;
	logic signed [interp_pkg::sample_w-1:0] smp_l;
	logic signed [interp_pkg::sample_w-1:0] smp_r;

	// Operands widened to accumulator width.
	logic signed [interp_pkg::out_w-1:0] coef_ext;
	logic signed [interp_pkg::out_w-1:0] smp_l_ext;
	logic signed [interp_pkg::out_w-1:0] smp_r_ext;

	// Products and updated sums.
	logic signed [interp_pkg::out_w-1:0] prod_l;
	logic signed [interp_pkg::out_w-1:0] prod_r;
	logic signed [interp_pkg::out_w-1:0] sum_l;
	logic signed [interp_pkg::out_w-1:0] sum_r;

	// Tap fetch.
	assign coef_cur = interp_pkg::coef_table[tap_idx];
	assign smp_l    = hist[tap_idx].left;
	assign smp_r    = hist[tap_idx].right;

	// Sign extension by hand.
	assign coef_ext = {
		{(interp_pkg::out_w - interp_pkg::coef_w){coef_cur[interp_pkg::coef_w-1]}},
		coef_cur
	};
	assign smp_l_ext = {
		{(interp_pkg::out_w - interp_pkg::sample_w){smp_l[interp_pkg::sample_w-1]}},
		smp_l
	};
	assign smp_r_ext = {
		{(interp_pkg::out_w - interp_pkg::sample_w){smp_r[interp_pkg::sample_w-1]}},
		smp_r
	};

	// Product needs 19 bits, so 20 never truncates.
	assign prod_l = coef_ext * smp_l_ext;
	assign prod_r = coef_ext * smp_r_ext;

	// Coefficient magnitude bound keeps these from wrapping.
	assign sum_l = acc.left + prod_l;
	assign sum_r = acc.right + prod_r;

	// History shift register.
	// Moves only in mac_shift, once per frame.
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < interp_pkg::num_taps; i++) begin
				hist[i] <= '0;
			end
		end else if (state == interp_pkg::mac_shift) begin
			for (int i = interp_pkg::num_taps - 1; i > 0; i--) begin
				hist[i] <= hist[i-1];
			end
			hist[0] <= frame;
		end
	end

	// Accumulators are cleared at the start of every frame.
	always_ff @(posedge clk) begin
		if (state == interp_pkg::mac_shift) begin
			acc <= '0;
		end else if (state == interp_pkg::mac_run) begin
			acc.left  <= sum_l;
			acc.right <= sum_r;
		end
	end

	// Filter FSM.
	// idle -> shift -> 16 x run -> emit -> idle.
	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= interp_pkg::mac_idle;
			tap_idx    <= '0;
			audio_out  <= '0;
			sample_out <= 1'b0;
		end else begin
			sample_out <= 1'b0;
			case (state)
				interp_pkg::mac_idle: begin
					if (frame_valid) begin
						state <= interp_pkg::mac_shift;
					end
				end
				interp_pkg::mac_shift: begin
					tap_idx <= '0;
					state   <= interp_pkg::mac_run;
				end
				interp_pkg::mac_run: begin
					tap_idx <= tap_idx + 1'b1;
					// Last tap lands straight in the output register.
					if (tap_idx == interp_pkg::tap_last) begin
						audio_out.left  <= sum_l;
						audio_out.right <= sum_r;
						sample_out      <= 1'b1;
						state           <= interp_pkg::mac_emit;
					end
				end
				default: begin
					// Output cycle, sample_out is high here.
					state <= interp_pkg::mac_idle;
				end
			endcase
		end
	end

	// Frames are one slot apart and a pass is shorter than a slot.
	// A frame outside idle means the slot timing broke.
	a_frame_in_idle : assert property (
		@(posedge clk) disable iff (rst)
		frame_valid |-> state == interp_pkg::mac_idle
	);

	// One output strobe per frame.
	a_sample_single : assert property (
		@(posedge clk) disable iff (rst)
		sample_out |=> !sample_out
	);

endmodule

`default_nettype wire

// ==== source/audio_interp.sv ====
`timescale 1ns/100ps
`default_nettype none

// Stereo interpolator top.
// Up-samples by two and mixes FM with a second source.
module audio_interp (
	input  logic                    clk,
	input  logic                    rst,
	input  interp_pkg::stereo_t     fm_in,
	input  interp_pkg::stereo_t     other_in,
	output interp_pkg::stereo_out_t audio_out,
	output logic                    sample_out
);

	// One strobe per slot.
	logic slot_tick;

	// Pair handed to the filter each slot.
	interp_pkg::stereo_t frame;
	logic frame_valid;

	// Slot timing.
	slot_timer u_slot_timer (
		.clk       (clk),
		.rst       (rst),
		.slot_tick (slot_tick)
	);

	// Source selection and zero stuffing.
	slot_sequencer u_slot_sequencer (
		.clk         (clk),
		.rst         (rst),
		.slot_tick   (slot_tick),
		.fm_in       (fm_in),
		.other_in    (other_in),
		.frame       (frame),
		.frame_valid (frame_valid)
	);

	// Low-pass interpolation filter.
	fir_mac u_fir_mac (
		.clk         (clk),
		.rst         (rst),
		.frame       (frame),
		.frame_valid (frame_valid),
		.audio_out   (audio_out),
		.sample_out  (sample_out)
	);

endmodule

`default_nettype wire

// ==== tb/audio_interp_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

// Testbench for the stereo interpolator.
// Drives both sources and checks every output against a software FIR.
module audio_interp_tb;

	// Reset length in clock cycles.
	localparam int reset_cycles = 10;

	// Tick at the last slot count and 19 cycles through the filter.
	localparam int first_out_delay = interp_pkg::slot_period + 19;

	// Test lengths in outputs.
	localparam int impulse_tail = 20;
	localparam int other_len = 40;
	localparam int random_len = 200;
	localparam int extreme_len = 40;

	// Startup pair and up to four alignment outputs ahead of the impulse and the tests.
	localparam int total_outputs = 1 + 4 + 1 + impulse_tail + other_len
		+ random_len + 2 * extreme_len;
	localparam int timeout_cycles = reset_cycles + first_out_delay
		+ (total_outputs + 1) * interp_pkg::slot_period;

	localparam logic [15:0] lfsr_seed = 16'd37;

	// Full-scale input values.
	localparam logic signed [interp_pkg::sample_w-1:0] sample_min =
		{1'b1, {(interp_pkg::sample_w - 1){1'b0}}};
	localparam logic signed [interp_pkg::sample_w-1:0] sample_max =
		{1'b0, {(interp_pkg::sample_w - 1){1'b1}}};

	// DUT ports.
	logic clk = 1'b0;
	logic rst;
	interp_pkg::stereo_t fm_in;
	interp_pkg::stereo_t other_in;
	interp_pkg::stereo_out_t audio_out;
	logic sample_out;

	// Model history with the newest pair at index 0.
	interp_pkg::stereo_t model_hist [0:interp_pkg::num_taps-1];
	logic [1:0] slot_pos = 2'd0;
	int exp_l [$];
	int exp_r [$];
	int out_cnt = 0;

	// Run bookkeeping.
	logic [15:0] lfsr_state;
	int cyc = 0;
	int rst_edge = 0;
	int last_pulse = 0;
	int seen = 0;
	int error_count = 0;
	int want_l;
	int want_r;

	// Last output pair, zero out of reset.
	int held_l = 0;
	int held_r = 0;

	audio_interp dut (
		.clk        (clk),
		.rst        (rst),
		.fm_in      (fm_in),
		.other_in   (other_in),
		.audio_out  (audio_out),
		.sample_out (sample_out)
	);

	// 100 ns period.
	always #50 clk = ~clk;

	task automatic abort_run();
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped on failure.");
	endtask

	task automatic check_value(input string name, input longint expected,
			input longint actual);
		if (actual != expected) begin
			error_count++;
			$display("** Error at %0t: %s expected %0d, got %0d",
				$time, name, expected, actual);
			abort_run();
		end
	endtask

	// Cycle count and run limit.
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= timeout_cycles) begin
			$display("Timeout: test did not finish within %0d cycles.", timeout_cycles);
			abort_run();
		end
	end

	// x^16 + x^14 + x^13 + x^11 + 1.
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step per bit.
	function automatic logic [interp_pkg::sample_w-1:0] random_bits();
		logic [interp_pkg::sample_w-1:0] v;
		v = '0;
		for (int b = 0; b < interp_pkg::sample_w; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[interp_pkg::sample_w-2:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic interp_pkg::stereo_t random_pair();
		interp_pkg::stereo_t p;
		p.left = random_bits();
		p.right = random_bits();
		return p;
	endfunction

	// Sum over taps of coefficient times history at full precision.
	function automatic void filter_ref(output int left, output int right);
		left = 0;
		right = 0;
		for (int i = 0; i < interp_pkg::num_taps; i++) begin
			left += int'(interp_pkg::coef_table[i]) * int'(model_hist[i].left);
			right += int'(interp_pkg::coef_table[i]) * int'(model_hist[i].right);
		end
	endfunction

	// Drives the pair for the next slot and queues the output it yields.
	task automatic apply_inputs(input interp_pkg::stereo_t fm,
			input interp_pkg::stereo_t other);
		interp_pkg::stereo_t pushed;
		int sum_l;
		int sum_r;
		fm_in <= fm;
		other_in <= other;
		// Zero slots push silence whatever the sources hold.
		case (interp_pkg::slot_e'(slot_pos))
			interp_pkg::slot_fm:    pushed = fm;
			interp_pkg::slot_other: pushed = other;
			default:                pushed = '0;
		endcase
		for (int i = interp_pkg::num_taps - 1; i > 0; i--) begin
			model_hist[i] = model_hist[i-1];
		end
		model_hist[0] = pushed;
		filter_ref(sum_l, sum_r);
		exp_l.push_back(sum_l);
		exp_r.push_back(sum_r);
		slot_pos = slot_pos + 2'd1;
		out_cnt++;
	endtask

	// Returns on the edge that sees sample_out high.
	task automatic wait_sample();
		@(posedge clk);
		while (!sample_out) begin
			@(posedge clk);
		end
	endtask

	// Next tick is 23 cycles after an output, so inputs change safely here.
	task automatic drive_next(input interp_pkg::stereo_t fm,
			input interp_pkg::stereo_t other);
		wait_sample();
		apply_inputs(fm, other);
	endtask

	task automatic expect_idle_outputs();
		check_value("sample_out", 0, sample_out);
		check_value("audio_out.left", 0, audio_out.left);
		check_value("audio_out.right", 0, audio_out.right);
	endtask

	// Output compare and pulse spacing.
	always @(posedge clk) begin
		if (sample_out) begin
			if (exp_l.size() == 0) begin
				$display("An output pulse arrived with no expected value pending.");
				abort_run();
			end else begin
				want_l = exp_l.pop_front();
				want_r = exp_r.pop_front();
				check_value("audio_out.left", want_l, audio_out.left);
				check_value("audio_out.right", want_r, audio_out.right);
				if (seen == 0) begin
					check_value("first sample_out delay", first_out_delay, cyc - rst_edge);
				end else begin
					check_value("sample_out spacing", interp_pkg::slot_period,
						cyc - last_pulse);
				end
				held_l = want_l;
				held_r = want_r;
				last_pulse = cyc;
				seen++;
			end
		end else if (!rst) begin
			// Between pulses the output keeps the last pair.
			check_value("audio_out.left", held_l, audio_out.left);
			check_value("audio_out.right", held_r, audio_out.right);
		end
	end

	initial begin
		interp_pkg::stereo_t zero_pair;
		interp_pkg::stereo_t impulse;
		interp_pkg::stereo_t low_pair;
		interp_pkg::stereo_t high_pair;
		zero_pair = '0;
		impulse = '0;
		impulse.left = {{(interp_pkg::sample_w - 1){1'b0}}, 1'b1};
		low_pair.left = sample_min;
		low_pair.right = sample_min;
		high_pair.left = sample_max;
		high_pair.right = sample_max;
		lfsr_state = lfsr_seed;
		for (int i = 0; i < interp_pkg::num_taps; i++) begin
			model_hist[i] = '0;
		end
		rst <= 1'b1;
		// Pair for the first FM slot.
		apply_inputs(zero_pair, zero_pair);

		// Outputs settle after the first reset edge.
		@(posedge clk);
		repeat (reset_cycles - 1) begin
			@(posedge clk);
			expect_idle_outputs();
		end
		rst <= 1'b0;
		rst_edge = cyc;
		repeat (interp_pkg::slot_period - 1) begin
			@(posedge clk);
			expect_idle_outputs();
		end

		// Impulse on FM left.
		// Left output walks the coefficient table.
		while (interp_pkg::slot_e'(slot_pos) != interp_pkg::slot_fm) begin
			drive_next(zero_pair, zero_pair);
		end
		drive_next(impulse, zero_pair);
		repeat (impulse_tail) begin
			drive_next(zero_pair, zero_pair);
		end

		// Second source only.
		repeat (other_len) begin
			drive_next(zero_pair, random_pair());
		end

		// Random values on all four channels.
		repeat (random_len) begin
			drive_next(random_pair(), random_pair());
		end

		// Full scale in both polarities.
		repeat (extreme_len) begin
			drive_next(low_pair, low_pair);
		end
		repeat (extreme_len) begin
			drive_next(high_pair, high_pair);
		end

		// Drain queued outputs.
		while (seen < out_cnt) begin
			@(posedge clk);
		end
		if (error_count == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule

`default_nettype wire

// ==== audio_interp.f ====
source/interp_pkg.sv
source/slot_timer.sv
source/slot_sequencer.sv
source/fir_mac.sv
source/audio_interp.sv
tb/audio_interp_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the audio interpolator testbench with Verilator.
# Exits non-zero when the log shows a failure or no result.

set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
	--top-module audio_interp_tb \
	-f audio_interp.f

# The pipe keeps a failing run from stopping the script before the log check.
./obj_dir/Vaudio_interp_tb 2>&1 | tee sim.log

if grep -qx "ERRORS FOUND" sim.log; then
	echo "Simulation failed."
	exit 1
fi

if ! grep -qx "NO ERRORS" sim.log; then
	echo "Simulation ended without a result."
	exit 1
fi

echo "Simulation passed."
